//--- design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  // datapath widths
  localparam int XLEN = 64;
  localparam int ILEN = 32;

  // pc or address value
  typedef logic [XLEN-1:0] xlen_t;

  // raw instruction word
  typedef logic [ILEN-1:0] inst_t;

  // 96 bit payload of every pipeline register
  typedef struct packed {
    xlen_t pc;     // fetch address of the instruction
    inst_t instr;  // instruction word as fetched
  } pipe_entry_t;

  // no compressed instructions in this core
  localparam xlen_t INST_BYTES = xlen_t'(4);

  // boot address of the usual riscv memory map
  localparam xlen_t DEFAULT_RESET_PC = 64'h0000_0000_8000_0000;

endpackage : pipe_pkg

`default_nettype wire

//--- design/fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc #(
  parameter pipe_pkg::xlen_t RESET_PC = pipe_pkg::DEFAULT_RESET_PC
) (
  input  wire logic                 clk,
  input  wire logic                 rst_i,

  input  wire logic                 fetch_valid_i,  // instr_i belongs to fetch_pc_o
  input  wire pipe_pkg::inst_t      instr_i,
  input  wire logic                 stall_i,        // whole pipe frozen

  input  wire logic                 redirect_i,     // jump or trap target strobe
  input  wire pipe_pkg::xlen_t      redirect_pc_i,

  output pipe_pkg::xlen_t           fetch_pc_o,
  output pipe_pkg::pipe_entry_t     entry_o,        // into stage 0
  output logic                      entry_valid_o
);

  import pipe_pkg::*;

  xlen_t pc_q;
  logic  accept;

  // a fetch is taken only when nothing else claims this cycle
  // the environment simply shows it again otherwise
  assign accept = fetch_valid_i & ~stall_i & ~redirect_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;      // taken even while stalled
    end else if (accept) begin
      pc_q <= pc_q + INST_BYTES;
    end
  end

  assign fetch_pc_o = pc_q;

  // stage 0 input entry
  assign entry_o = '{pc: pc_q, instr: instr_i};
  assign entry_valid_o = accept;

endmodule : fetch_pc

`default_nettype wire

//--- design/pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl #(
  parameter int unsigned NUM_STAGES  = 4,
  parameter int unsigned FLUSH_DEPTH = 2
) (
  input  wire logic                  ls_busy_i,   // load/store not done yet
  input  wire logic                  redirect_i,

  output logic [NUM_STAGES-1:0]      advance_o,
  output logic [NUM_STAGES-1:0]      flush_o,
  output logic                       stall_o      // to the fetch counter
);

  // memory busy freezes every stage and the fetch side together
  assign stall_o   = ls_busy_i;
  assign advance_o = {NUM_STAGES{~ls_busy_i}};

  // stage 0 is the youngest, index NUM_STAGES-1 the oldest
  //
  // on a redirect the entries now sitting in the FLUSH_DEPTH youngest
  // stages are killed. when the pipe moves, the one stage just above
  // that window would pick up a killed entry, so it is cleared too.
  // when the pipe is frozen it keeps its own older entry
  always_comb begin
    for (int k = 0; k < NUM_STAGES; k++) begin
      if (k < FLUSH_DEPTH) begin
        flush_o[k] = redirect_i;
      end else if (k == FLUSH_DEPTH) begin
        flush_o[k] = redirect_i & ~ls_busy_i;  // input came from a dead stage
      end else begin
        flush_o[k] = 1'b0;
      end
    end
  end

endmodule : pipe_ctrl

`default_nettype wire

//--- design/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg (
  input  wire logic                   clk,
  input  wire logic                   rst_i,

  input  wire logic                   advance_i,  // take the younger stage's entry
  input  wire logic                   flush_i,    // drop whatever ends up here

  input  wire pipe_pkg::pipe_entry_t  entry_i,
  input  wire logic                   valid_i,

  output pipe_pkg::pipe_entry_t       entry_o,
  output logic                        valid_o
);

  import pipe_pkg::*;

  pipe_entry_t entry_q;
  logic        valid_q;

  // flush wins over advance for the valid bit
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (advance_i) begin
      valid_q <= valid_i;
    end
  end

  // payload just follows advance
  always_ff @(posedge clk) begin
    if (advance_i) begin
      entry_q <= entry_i;
    end
  end

  assign entry_o = entry_q;
  assign valid_o = valid_q;

endmodule : stage_reg

`default_nettype wire

//--- design/retire_unit.sv
`timescale 1ns/1ps
`default_nettype none

module retire_unit #(
  parameter int unsigned CNT_W = 32
) (
  input  wire logic                   clk,
  input  wire logic                   rst_i,

  // oldest stage of the chain
  input  wire pipe_pkg::pipe_entry_t  entry_i,
  input  wire logic                   valid_i,
  input  wire logic                   advance_i,

  // commit trace for difftest
  output logic                        commit_o,
  output pipe_pkg::xlen_t             commit_pc_o,
  output pipe_pkg::inst_t             commit_instr_o,

  output logic [CNT_W-1:0]            retire_count_o
);

  logic [CNT_W-1:0] count_q;

  // an entry retires in the cycle it leaves the last stage
  // one cycle per instruction since the stage empties or refills
  assign commit_o       = valid_i & advance_i;
  assign commit_pc_o    = entry_i.pc;
  assign commit_instr_o = entry_i.instr;

  // retired instruction count that wraps silently
  always_ff @(posedge clk) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (commit_o) begin
      count_q <= count_q + CNT_W'(1);
    end
  end

  assign retire_count_o = count_q;

endmodule : retire_unit

`default_nettype wire

//--- design/core_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_pipe_top #(
  parameter pipe_pkg::xlen_t RESET_PC    = pipe_pkg::DEFAULT_RESET_PC,
  parameter int unsigned     NUM_STAGES  = 4,   // id, ex, ls, wb
  parameter int unsigned     FLUSH_DEPTH = 2,   // stages younger than ls
  parameter int unsigned     CNT_W       = 32
) (
  input  wire logic               clk,
  input  wire logic               rst_i,

  // instruction delivery
  input  wire logic               fetch_valid_i,
  input  wire pipe_pkg::inst_t    instr_i,

  // memory side busy stalls all stages
  input  wire logic               ls_busy_i,

  // jump or trap
  input  wire logic               redirect_i,
  input  wire pipe_pkg::xlen_t    redirect_pc_i,

  output pipe_pkg::xlen_t         fetch_pc_o,

  // commit trace
  output logic                    commit_o,
  output pipe_pkg::xlen_t         commit_pc_o,
  output pipe_pkg::inst_t         commit_instr_o,
  output logic [CNT_W-1:0]        retire_count_o
);

  import pipe_pkg::*;

  // chain slot 0 is the fetch output, slot k+1 the output of stage k
  pipe_entry_t             stage_entry [NUM_STAGES+1];
  logic [NUM_STAGES:0]     stage_valid;

  logic [NUM_STAGES-1:0]   advance;
  logic [NUM_STAGES-1:0]   flush;
  logic                    stall;

  fetch_pc #(
    .RESET_PC      (RESET_PC)
  ) u_fetch_pc (
    .clk           (clk),
    .rst_i         (rst_i),
    .fetch_valid_i (fetch_valid_i),
    .instr_i       (instr_i),
    .stall_i       (stall),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .fetch_pc_o    (fetch_pc_o),
    .entry_o       (stage_entry[0]),
    .entry_valid_o (stage_valid[0])
  );

  pipe_ctrl #(
    .NUM_STAGES  (NUM_STAGES),
    .FLUSH_DEPTH (FLUSH_DEPTH)
  ) u_pipe_ctrl (
    .ls_busy_i   (ls_busy_i),
    .redirect_i  (redirect_i),
    .advance_o   (advance),
    .flush_o     (flush),
    .stall_o     (stall)
  );

  // id, ex, ls, wb registers with the default depth
  for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
    stage_reg u_stage_reg (
      .clk       (clk),
      .rst_i     (rst_i),
      .advance_i (advance[k]),
      .flush_i   (flush[k]),
      .entry_i   (stage_entry[k]),
      .valid_i   (stage_valid[k]),
      .entry_o   (stage_entry[k+1]),
      .valid_o   (stage_valid[k+1])
    );
  end

  // drains the wb register
  retire_unit #(
    .CNT_W          (CNT_W)
  ) u_retire_unit (
    .clk            (clk),
    .rst_i          (rst_i),
    .entry_i        (stage_entry[NUM_STAGES]),
    .valid_i        (stage_valid[NUM_STAGES]),
    .advance_i      (advance[NUM_STAGES-1]),
    .commit_o       (commit_o),
    .commit_pc_o    (commit_pc_o),
    .commit_instr_o (commit_instr_o),
    .retire_count_o (retire_count_o)
  );

endmodule : core_pipe_top

`default_nettype wire

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);

  // free running clock that starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

endmodule : tb_clk_gen

`default_nettype wire

//--- tb/core_pipe_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module core_pipe_asserts #(
  parameter int unsigned CNT_W = 32
) (
  input wire logic              clk,
  input wire logic              rst_i,
  input wire logic              ls_busy_i,
  input wire logic              redirect_i,
  input wire pipe_pkg::xlen_t   fetch_pc_i,
  input wire logic              commit_i,
  input wire pipe_pkg::xlen_t   commit_pc_i,
  input wire pipe_pkg::inst_t   commit_instr_i,
  input wire logic [CNT_W-1:0]  retire_count_i
);

  int fail_count = 0;  // assertions failed so far

  // a frozen pipe retires nothing
  no_commit_when_busy: assert property (@(posedge clk) disable iff (rst_i)
    !(commit_i && ls_busy_i))
  else begin
    $error("commit_o high while ls_busy_i is high");
    fail_count++;
  end

  // fetch counter frozen unless a redirect comes in
  pc_holds_when_busy: assert property (@(posedge clk) disable iff (rst_i)
    (ls_busy_i && !redirect_i) |=> $stable(fetch_pc_i))
  else begin
    $error("fetch_pc_o moved during a stall");
    fail_count++;
  end

  // trace payload only matters alongside commit
  outputs_known: assert property (@(posedge clk) disable iff (rst_i)
    !$isunknown({fetch_pc_i, commit_i, retire_count_i}) &&
    (!commit_i || !$isunknown({commit_pc_i, commit_instr_i})))
  else begin
    $error("unknown value on a DUT output");
    fail_count++;
  end

endmodule : core_pipe_asserts

bind core_pipe_top core_pipe_asserts #(
  .CNT_W          (CNT_W)
) u_core_pipe_asserts (
  .clk            (clk),
  .rst_i          (rst_i),
  .ls_busy_i      (ls_busy_i),
  .redirect_i     (redirect_i),
  .fetch_pc_i     (fetch_pc_o),
  .commit_i       (commit_o),
  .commit_pc_i    (commit_pc_o),
  .commit_instr_i (commit_instr_o),
  .retire_count_i (retire_count_o)
);

`default_nettype wire

//--- tb/tb_core_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_pipe;

  import pipe_pkg::*;

  localparam int    CLK_PERIOD   = 40;
  localparam int    RESET_CYCLES = 4;
  localparam int    NUM_STAGES   = 4;   // DUT defaults
  localparam int    FLUSH_DEPTH  = 2;
  localparam int    CNT_W        = 32;
  localparam xlen_t RESET_PC     = DEFAULT_RESET_PC;
  localparam xlen_t PC_STEP      = 64'd4;

  // one row per clock cycle
  typedef struct packed {
    logic  fetch_valid;
    logic  busy;
    logic  redirect;
    xlen_t target;
  } stim_row_t;

  // accepted instruction with the stage it sits in as its age
  typedef struct packed {
    xlen_t      pc;
    inst_t      instr;
    logic [7:0] age;
  } model_entry_t;

  logic             clk;
  logic             rst_i;
  logic             fetch_valid_i;
  inst_t            instr_i;
  logic             ls_busy_i;
  logic             redirect_i;
  xlen_t            redirect_pc_i;
  xlen_t            fetch_pc_o;
  logic             commit_o;
  xlen_t            commit_pc_o;
  inst_t            commit_instr_o;
  logic [CNT_W-1:0] retire_count_o;

  stim_row_t        stim [$];
  model_entry_t     model_q [$];    // oldest at the front
  xlen_t            model_pc;
  logic [CNT_W-1:0] model_count;
  int               timeout_limit;
  int               cycle_count;
  logic             table_ready;

  tb_clk_gen #(
    .PERIOD_NS (CLK_PERIOD)
  ) u_tb_clk_gen (
    .clk_o     (clk)
  );

  core_pipe_top u_core_pipe_top (
    .clk            (clk),
    .rst_i          (rst_i),
    .fetch_valid_i  (fetch_valid_i),
    .instr_i        (instr_i),
    .ls_busy_i      (ls_busy_i),
    .redirect_i     (redirect_i),
    .redirect_pc_i  (redirect_pc_i),
    .fetch_pc_o     (fetch_pc_o),
    .commit_o       (commit_o),
    .commit_pc_o    (commit_pc_o),
    .commit_instr_o (commit_instr_o),
    .retire_count_o (retire_count_o)
  );

  task automatic abort_run(input string why);
    $display("tests failed");
    $fatal(1, "%s", why);
  endtask

  task automatic xlen_compare(input string name, input xlen_t exp_v, input xlen_t act_v);
    if (act_v !== exp_v) begin
      $display("FAIL t=%0t %s expected 0x%h actual 0x%h", $time, name, exp_v, act_v);
      abort_run("value mismatch");
    end
  endtask

  task automatic inst_compare(input string name, input inst_t exp_v, input inst_t act_v);
    if (act_v !== exp_v) begin
      $display("FAIL t=%0t %s expected 0x%h actual 0x%h", $time, name, exp_v, act_v);
      abort_run("value mismatch");
    end
  endtask

  task automatic commit_compare(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp_v, act_v);
      abort_run("value mismatch");
    end
  endtask

  task automatic count_compare(input string name, input logic [CNT_W-1:0] exp_v,
                               input logic [CNT_W-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
      abort_run("value mismatch");
    end
  endtask

  task automatic add_rows(input int count, input logic fv, input logic busy,
                          input logic redir, input xlen_t target);
    stim_row_t row;
    row = '{fetch_valid: fv, busy: busy, redirect: redir, target: target};
    repeat (count) stim.push_back(row);
  endtask

  task automatic build_table();
    add_rows(8, 1'b1, 1'b0, 1'b0, '0);   // back to back fetches
    add_rows(4, 1'b0, 1'b0, 1'b0, '0);   // drain
    add_rows(3, 1'b1, 1'b0, 1'b0, '0);
    add_rows(3, 1'b1, 1'b1, 1'b0, '0);   // strobes dropped while stalled
    add_rows(5, 1'b0, 1'b0, 1'b0, '0);
    add_rows(4, 1'b1, 1'b0, 1'b0, '0);
    add_rows(1, 1'b1, 1'b0, 1'b1, 64'h0000_0000_8000_1000);  // jump while moving
    add_rows(4, 1'b1, 1'b0, 1'b0, '0);
    add_rows(5, 1'b0, 1'b0, 1'b0, '0);
    add_rows(4, 1'b1, 1'b0, 1'b0, '0);
    add_rows(1, 1'b1, 1'b1, 1'b1, 64'h0000_0000_8000_2000);  // trap during a stall
    add_rows(2, 1'b1, 1'b1, 1'b0, '0);
    add_rows(2, 1'b1, 1'b0, 1'b0, '0);
    add_rows(6, 1'b0, 1'b0, 1'b0, '0);
  endtask

  // oldest entry leaves only from the last stage and only when not busy
  function automatic logic expected_commit(input stim_row_t row);
    return (model_q.size() > 0) && (model_q[0].age == NUM_STAGES - 1) && !row.busy;
  endfunction

  // advance the model across one clock edge
  task automatic step_model(input stim_row_t row, input inst_t instr, input logic committed);
    model_entry_t next_q [$];
    model_entry_t e;
    logic         accept;

    accept = row.fetch_valid && !row.busy && !row.redirect;
    foreach (model_q[i]) begin
      e = model_q[i];
      if (row.redirect && e.age < FLUSH_DEPTH) begin
        // killed in a young stage
      end else if (!row.busy && e.age == NUM_STAGES - 1) begin
        // retired this cycle
      end else begin
        if (!row.busy) begin
          e.age = e.age + 8'd1;
        end
        next_q.push_back(e);
      end
    end

    if (accept) begin
      e = '{pc: model_pc, instr: instr, age: 8'd0};
      next_q.push_back(e);
    end
    model_q = next_q;

    if (row.redirect) begin
      model_pc = row.target;
    end else if (accept) begin
      model_pc = model_pc + PC_STEP;
    end
    if (committed) begin
      model_count = model_count + 1'b1;
    end
  endtask

  task automatic drive_row(input stim_row_t row, input inst_t instr);
    fetch_valid_i = row.fetch_valid;
    instr_i       = instr;
    ls_busy_i     = row.busy;
    redirect_i    = row.redirect;
    redirect_pc_i = row.target;
  endtask

  initial begin
    stim_row_t row;
    inst_t     instr;
    logic      exp_commit;

    rst_i         = 1'b1;
    fetch_valid_i = 1'b0;
    instr_i       = '0;
    ls_busy_i     = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    table_ready   = 1'b0;
    void'($urandom(79));

    build_table();
    timeout_limit = stim.size() + 20;
    table_ready   = 1'b1;
    model_pc      = RESET_PC;
    model_count   = '0;

    repeat (RESET_CYCLES) @(posedge clk);

    foreach (stim[i]) begin
      row   = stim[i];
      instr = $urandom();
      @(negedge clk);
      rst_i = 1'b0;
      drive_row(row, instr);
      #(CLK_PERIOD / 4);  // outputs settled by mid low phase

      exp_commit = expected_commit(row);
      xlen_compare("fetch_pc_o", model_pc, fetch_pc_o);
      count_compare("retire_count_o", model_count, retire_count_o);
      commit_compare("commit_o", exp_commit, commit_o);
      if (exp_commit) begin
        xlen_compare("commit_pc_o", model_q[0].pc, commit_pc_o);
        inst_compare("commit_instr_o", model_q[0].instr, commit_instr_o);
      end
      step_model(row, instr, exp_commit);
    end

    // last edge still updates the counter
    @(negedge clk);
    fetch_valid_i = 1'b0;
    ls_busy_i     = 1'b0;
    redirect_i    = 1'b0;
    #(CLK_PERIOD / 4);
    count_compare("retire_count_o", model_count, retire_count_o);

    if (u_core_pipe_top.u_core_pipe_asserts.fail_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      abort_run("assertion failures in core_pipe_asserts");
    end
  end

  // stop at the first assertion failure
  initial begin
    wait (u_core_pipe_top.u_core_pipe_asserts.fail_count != 0);
    $display("an assertion in core_pipe_asserts failed at t=%0t", $time);
    abort_run("assertion failure");
  end

  initial begin
    cycle_count = 0;
    wait (table_ready === 1'b1);
    while (cycle_count < timeout_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run timed out after %0d cycles", cycle_count);
    abort_run("timeout");
  end

endmodule : tb_core_pipe

`default_nettype wire

//--- src.f
design/pipe_pkg.sv
design/fetch_pc.sv
design/pipe_ctrl.sv
design/stage_reg.sv
design/retire_unit.sv
design/core_pipe_top.sv
tb/tb_clk_gen.sv
tb/core_pipe_asserts.sv
tb/tb_core_pipe.sv

//--- Bender.yml
package:
  name: core_pipe

sources:
  - design/pipe_pkg.sv
  - design/fetch_pc.sv
  - design/pipe_ctrl.sv
  - design/stage_reg.sv
  - design/retire_unit.sv
  - design/core_pipe_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/core_pipe_asserts.sv
      - tb/tb_core_pipe.sv
